// File: common/controlPkg.sv
package controlPkg;

    import isaPkg::*;

    typedef enum logic [4:0] {
        ALU_ADD = 5'd1,
        ALU_SUB = 5'd2,
        ALU_AND = 5'd3,
        ALU_OR  = 5'd4,
        ALU_SLT = 5'd7,
        ALU_EQ  = 5'd15,
        ALU_NE  = 5'd14,
        ALU_LE  = 5'd16,
        ALU_GT  = 5'd17
    } aluOp_t;

    typedef enum logic [2:0] {
        SH_NONE        = 3'd0,
        SH_LOAD        = 3'd1,
        SH_LEFT        = 3'd2,
        SH_RIGHT_LOGIC = 3'd3,
        SH_RIGHT_ARITH = 3'd4
    } shiftType_t;

    typedef enum logic [1:0] {
        SHS_REG   = 2'd0,  // rs holds the amount
        SHS_SHAMT = 2'd2
    } shiftSrc_t;

    typedef enum logic {SRCA_PC, SRCA_REG} aluSrcA_t;

    typedef enum logic [2:0] {
        SRCB_REG           = 3'd0,
        SRCB_FOUR          = 3'd1,
        SRCB_IMM           = 3'd2,
        SRCB_BRANCH_OFFSET = 3'd3
    } aluSrcB_t;

    typedef enum logic [2:0] {
        PCS_JUMP_TARGET = 3'd0,
        PCS_ALU_OUT     = 3'd1,
        PCS_ALU_RESULT  = 3'd2
    } pcSource_t;

    typedef enum logic [2:0] {
        M2R_ALU_OUT  = 3'd0,
        M2R_MEM_DATA = 3'd1,
        M2R_SHIFTER  = 3'd2,
        M2R_PC       = 3'd4  // return address for jal
    } memToReg_t;

    typedef enum logic [1:0] {RD_RT, RD_RD, RD_RA} regDest_t;

    typedef enum logic [3:0] {
        ST_IDLE, ST_FETCH, ST_DECODE, ST_EXECUTE,
        ST_SHIFT_LOAD, ST_SHIFT_RUN, ST_ALU_WRITEBACK,
        ST_BRANCH_TARGET, ST_BRANCH_COMPARE,
        ST_ADDR_CALC, ST_MEM_READ, ST_MEM_WAIT, ST_MEM_WRITEBACK, ST_MEM_WRITE,
        ST_JUMP
    } seqState_t;

    typedef struct packed {
        instrClass_t instrClass;
        aluOp_t      aluOp;
        shiftType_t  shiftType;
        shiftSrc_t   shiftSrc;
        aluSrcB_t    aluSrcB;
        regDest_t    writeDest;
        memToReg_t   writeSource;
    } decodedInstr_t;

    typedef struct packed {
        logic       pcWrite;
        logic       pcWriteCond;
        pcSource_t  pcSource;
        logic       iorD;
        logic       memRead;
        logic       memWrite;
        logic       irWrite;
        logic       regWrite;
        regDest_t   regDest;
        memToReg_t  memToReg;
        aluSrcA_t   aluSrcA;
        aluSrcB_t   aluSrcB;
        aluOp_t     aluOp;
        logic       aluOutLoad;
        shiftSrc_t  shiftSrc;
        shiftType_t shiftType;
    } controlWord_t;

    localparam controlWord_t IDLE_WORD = '{
        pcWrite: 1'b0, pcWriteCond: 1'b0, pcSource: PCS_JUMP_TARGET,
        iorD: 1'b0, memRead: 1'b0, memWrite: 1'b0, irWrite: 1'b0,
        regWrite: 1'b0, regDest: RD_RT, memToReg: M2R_ALU_OUT,
        aluSrcA: SRCA_PC, aluSrcB: SRCB_REG, aluOp: ALU_ADD,
        aluOutLoad: 1'b0, shiftSrc: SHS_REG, shiftType: SH_NONE
    };

endpackage

// File: common/isaPkg.sv
package isaPkg;

    typedef logic [5:0] opcode_t;
    typedef logic [5:0] funct_t;

    // primary opcodes
    localparam opcode_t OP_RTYPE = 6'd0;
    localparam opcode_t OP_J     = 6'd2;
    localparam opcode_t OP_JAL   = 6'd3;
    localparam opcode_t OP_BEQ   = 6'd4;
    localparam opcode_t OP_BNE   = 6'd5;
    localparam opcode_t OP_BLE   = 6'd6;
    localparam opcode_t OP_BGT   = 6'd7;
    localparam opcode_t OP_ADDI  = 6'd8;
    localparam opcode_t OP_ADDIU = 6'd9;
    localparam opcode_t OP_SLTI  = 6'd10;
    localparam opcode_t OP_LW    = 6'd35;
    localparam opcode_t OP_SW    = 6'd43;

    // funct field, R-type only
    localparam funct_t FN_SLL  = 6'd0;
    localparam funct_t FN_SRL  = 6'd2;
    localparam funct_t FN_SRA  = 6'd3;
    localparam funct_t FN_SLLV = 6'd4;
    localparam funct_t FN_SRAV = 6'd7;
    localparam funct_t FN_ADD  = 6'd32;
    localparam funct_t FN_SUB  = 6'd34;
    localparam funct_t FN_AND  = 6'd36;
    localparam funct_t FN_OR   = 6'd37;
    localparam funct_t FN_SLT  = 6'd42;

    typedef enum logic [3:0] {
        CLS_ALU_REG,
        CLS_ALU_IMM,
        CLS_SHIFT,
        CLS_BRANCH,
        CLS_LOAD,
        CLS_STORE,
        CLS_JUMP,
        CLS_JAL,
        CLS_ILLEGAL
    } instrClass_t;

endpackage

// File: controlUnit.f
common/isaPkg.sv
common/controlPkg.sv
hw/instructionDecoder.sv
hw/controlSequencer.sv
hw/controlWordEncoder.sv
hw/controlUnit.sv
tb/clockGen.sv
tb/controlUnitTb.sv

// File: hw/controlSequencer.sv
`timescale 1ns/1ps

module controlSequencer
    import isaPkg::*, controlPkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  instrClass_t instrClass,
    output seqState_t   state
);

    seqState_t nextState;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state <= ST_IDLE;
        end
        else
        begin
            state <= nextState;
        end
    end

    always_comb
    begin
        nextState = ST_FETCH;
        case (state)
            ST_IDLE:  nextState = ST_FETCH;
            ST_FETCH: nextState = ST_DECODE;
            ST_DECODE:
            begin
                // first class specific cycle
                case (instrClass)
                    CLS_ALU_REG, CLS_ALU_IMM: nextState = ST_EXECUTE;
                    CLS_SHIFT:                nextState = ST_SHIFT_LOAD;
                    CLS_BRANCH:               nextState = ST_BRANCH_TARGET;
                    CLS_LOAD, CLS_STORE:      nextState = ST_ADDR_CALC;
                    CLS_JUMP, CLS_JAL:        nextState = ST_JUMP;
                    default:                  nextState = ST_FETCH;  // undefined goes back to fetch
                endcase
            end
            ST_EXECUTE:        nextState = ST_ALU_WRITEBACK;
            ST_SHIFT_LOAD:     nextState = ST_SHIFT_RUN;
            ST_SHIFT_RUN:      nextState = ST_ALU_WRITEBACK;
            ST_BRANCH_TARGET:  nextState = ST_BRANCH_COMPARE;
            ST_ADDR_CALC:
            begin
                if (instrClass == CLS_STORE)
                begin
                    nextState = ST_MEM_WRITE;
                end
                else
                begin
                    nextState = ST_MEM_READ;
                end
            end
            ST_MEM_READ:       nextState = ST_MEM_WAIT;
            ST_MEM_WAIT:       nextState = ST_MEM_WRITEBACK;  // memory has one wait cycle
            ST_ALU_WRITEBACK,
            ST_BRANCH_COMPARE,
            ST_MEM_WRITEBACK,
            ST_MEM_WRITE,
            ST_JUMP:           nextState = ST_FETCH;
            default:           nextState = ST_FETCH;
        endcase
    end

endmodule

// File: hw/controlUnit.sv
`timescale 1ns/1ps

module controlUnit
    import isaPkg::*, controlPkg::*;
(
    input  logic         clk,
    input  logic         reset,
    input  opcode_t      opcode,
    input  funct_t       funct,
    output controlWord_t ctrl
);

    decodedInstr_t decoded;
    seqState_t     state;

    instructionDecoder decoder (
        .opcode  (opcode),
        .funct   (funct),
        .decoded (decoded)
    );

    controlSequencer sequencer (
        .clk        (clk),
        .reset      (reset),
        .instrClass (decoded.instrClass),
        .state      (state)
    );

    controlWordEncoder encoder (
        .state   (state),
        .decoded (decoded),
        .ctrl    (ctrl)
    );

endmodule

// File: hw/controlWordEncoder.sv
`timescale 1ns/1ps

module controlWordEncoder
    import controlPkg::*;
(
    input  seqState_t     state,
    input  decodedInstr_t decoded,
    output controlWord_t  ctrl
);

    always_comb
    begin
        ctrl = IDLE_WORD;
        case (state)
            ST_FETCH:
            begin
                ctrl.memRead = 1'b1;
                ctrl.irWrite = 1'b1;
                ctrl.iorD    = 1'b0;  // address from pc
            end
            ST_DECODE:
            begin
                // pc + 4
                ctrl.aluSrcA  = SRCA_PC;
                ctrl.aluSrcB  = SRCB_FOUR;
                ctrl.aluOp    = ALU_ADD;
                ctrl.pcWrite  = 1'b1;
                ctrl.pcSource = PCS_ALU_RESULT;
            end
            ST_EXECUTE:
            begin
                ctrl.aluSrcA    = SRCA_REG;
                ctrl.aluSrcB    = decoded.aluSrcB;
                ctrl.aluOp      = decoded.aluOp;
                ctrl.aluOutLoad = 1'b1;
            end
            ST_SHIFT_LOAD:
            begin
                ctrl.shiftType = SH_LOAD;
                ctrl.shiftSrc  = decoded.shiftSrc;
            end
            ST_SHIFT_RUN: ctrl.shiftType = decoded.shiftType;
            ST_ALU_WRITEBACK, ST_MEM_WRITEBACK:
            begin
                ctrl.regWrite = 1'b1;
                ctrl.regDest  = decoded.writeDest;
                ctrl.memToReg = decoded.writeSource;
            end
            ST_BRANCH_TARGET:
            begin
                // target kept in aluOut for the compare cycle
                ctrl.aluSrcA    = SRCA_PC;
                ctrl.aluSrcB    = SRCB_BRANCH_OFFSET;
                ctrl.aluOp      = ALU_ADD;
                ctrl.aluOutLoad = 1'b1;
            end
            ST_BRANCH_COMPARE:
            begin
                ctrl.aluSrcA     = SRCA_REG;
                ctrl.aluSrcB     = SRCB_REG;
                ctrl.aluOp       = decoded.aluOp;
                ctrl.pcWriteCond = 1'b1;
                ctrl.pcSource    = PCS_ALU_OUT;
            end
            ST_ADDR_CALC:
            begin
                ctrl.aluSrcA    = SRCA_REG;
                ctrl.aluSrcB    = SRCB_IMM;
                ctrl.aluOp      = ALU_ADD;
                ctrl.aluOutLoad = 1'b1;
            end
            ST_MEM_READ, ST_MEM_WAIT:
            begin
                ctrl.iorD    = 1'b1;
                ctrl.memRead = 1'b1;
            end
            ST_MEM_WRITE:
            begin
                ctrl.iorD     = 1'b1;
                ctrl.memWrite = 1'b1;
            end
            ST_JUMP:
            begin
                ctrl.pcWrite  = 1'b1;
                ctrl.pcSource = PCS_JUMP_TARGET;
                if (decoded.writeDest == RD_RA)  // jal links
                begin
                    ctrl.regWrite = 1'b1;
                    ctrl.regDest  = decoded.writeDest;
                    ctrl.memToReg = decoded.writeSource;
                end
            end
            default: ctrl = IDLE_WORD;
        endcase
    end

endmodule

// File: hw/instructionDecoder.sv
`timescale 1ns/1ps

module instructionDecoder
    import isaPkg::*, controlPkg::*;
(
    input  opcode_t       opcode,
    input  funct_t        funct,
    output decodedInstr_t decoded
);

    always_comb
    begin
        decoded.instrClass  = CLS_ILLEGAL;
        decoded.aluOp       = ALU_ADD;
        decoded.shiftType   = SH_NONE;
        decoded.shiftSrc    = SHS_REG;
        decoded.aluSrcB     = SRCB_IMM;
        decoded.writeDest   = RD_RT;
        decoded.writeSource = M2R_ALU_OUT;

        case (opcode)
            OP_RTYPE:
            begin
                decoded.aluSrcB   = SRCB_REG;
                decoded.writeDest = RD_RD;
                case (funct)
                    FN_ADD, FN_SUB, FN_AND, FN_OR, FN_SLT:
                    begin
                        decoded.instrClass = CLS_ALU_REG;
                        case (funct)
                            FN_SUB:  decoded.aluOp = ALU_SUB;
                            FN_AND:  decoded.aluOp = ALU_AND;
                            FN_OR:   decoded.aluOp = ALU_OR;
                            FN_SLT:  decoded.aluOp = ALU_SLT;
                            default: decoded.aluOp = ALU_ADD;
                        endcase
                    end
                    FN_SLL, FN_SRL, FN_SRA, FN_SLLV, FN_SRAV:
                    begin
                        decoded.instrClass  = CLS_SHIFT;
                        decoded.writeSource = M2R_SHIFTER;
                        // variable shifts take the amount from rs
                        decoded.shiftSrc = (funct == FN_SLLV || funct == FN_SRAV) ?
                                           SHS_REG : SHS_SHAMT;
                        case (funct)
                            FN_SLL, FN_SLLV: decoded.shiftType = SH_LEFT;
                            FN_SRL:          decoded.shiftType = SH_RIGHT_LOGIC;
                            default:         decoded.shiftType = SH_RIGHT_ARITH;
                        endcase
                    end
                    default: decoded.instrClass = CLS_ILLEGAL;
                endcase
            end
            OP_ADDI, OP_ADDIU: decoded.instrClass = CLS_ALU_IMM;
            OP_SLTI:
            begin
                decoded.instrClass = CLS_ALU_IMM;
                decoded.aluOp      = ALU_SLT;
            end
            OP_BEQ, OP_BNE, OP_BLE, OP_BGT:
            begin
                decoded.instrClass = CLS_BRANCH;
                case (opcode)
                    OP_BNE:  decoded.aluOp = ALU_NE;
                    OP_BLE:  decoded.aluOp = ALU_LE;
                    OP_BGT:  decoded.aluOp = ALU_GT;
                    default: decoded.aluOp = ALU_EQ;
                endcase
            end
            OP_LW:
            begin
                decoded.instrClass  = CLS_LOAD;
                decoded.writeSource = M2R_MEM_DATA;
            end
            OP_SW:   decoded.instrClass = CLS_STORE;
            OP_J:    decoded.instrClass = CLS_JUMP;
            OP_JAL:
            begin
                decoded.instrClass  = CLS_JAL;
                decoded.writeDest   = RD_RA;  // link register
                decoded.writeSource = M2R_PC;
            end
            default: decoded.instrClass = CLS_ILLEGAL;
        endcase
    end

endmodule

// File: tb/clockGen.sv
`timescale 1ns/1ps

module clockGen (
    output logic clk,
    output logic reset
);

    initial
    begin
        clk = 1'b0;
        forever #2 clk = ~clk;  // 4 ns period
    end

    initial
    begin
        reset = 1'b1;
        repeat (4) @(posedge clk);
        reset <= 1'b0;
    end

endmodule

// File: tb/controlUnitTb.sv
`timescale 1ns/1ps

module controlUnitTb
    import isaPkg::*, controlPkg::*;
();

    localparam int NUM_INSTR  = 400;
    localparam int MAX_CYCLES = NUM_INSTR * 6 + 20;  // longest class is 6 cycles

    logic         clk;
    logic         reset;
    opcode_t      opcode;
    funct_t       funct;
    controlWord_t ctrl;

    integer  seed = 32'hf79a;
    int      cycles = 0;
    opcode_t nextOp;
    funct_t  nextFunct;

    opcode_t opTable [11] = '{OP_J, OP_JAL, OP_ADDI, OP_ADDIU, OP_SLTI, OP_BEQ,
                              OP_BNE, OP_BLE, OP_BGT, OP_LW, OP_SW};
    funct_t  fnTable [10] = '{FN_SLL, FN_SRL, FN_SRA, FN_SLLV, FN_SRAV,
                              FN_ADD, FN_SUB, FN_AND, FN_OR, FN_SLT};

    // reference decode of the current instruction
    instrClass_t expClass;
    aluOp_t      expAluOp;
    shiftType_t  expShiftType;
    shiftSrc_t   expShiftSrc;
    aluSrcB_t    expSrcB;
    regDest_t    expDest;
    memToReg_t   expSource;
    seqState_t   steps [$];

    clockGen clocks (
        .clk   (clk),
        .reset (reset)
    );

    controlUnit UUT (
        .clk    (clk),
        .reset  (reset),
        .opcode (opcode),
        .funct  (funct),
        .ctrl   (ctrl)
    );

    task automatic abortRun(input string why);
        $display("%s", why);
        $display("Something failed");
        $fatal(1, "run aborted");
    endtask

    task automatic checkControlWord(input controlWord_t actual, input controlWord_t expected);
        if (actual !== expected)
            abortRun($sformatf("[FAIL] time %0t: ctrl = %h, expected %h",
                               $time, actual, expected));
    endtask

    task pickInstruction();
        int roll;
        roll      = {$random(seed)} % 16;
        nextOp    = (roll < 6) ? OP_RTYPE : opTable[{$random(seed)} % 11];
        nextFunct = fnTable[{$random(seed)} % 10];
        if (roll == 0)
            nextFunct = funct_t'($random(seed));  // mostly undefined functs
        if (roll == 15)
            nextOp = opcode_t'($random(seed));
    endtask

    task setRegAlu(input aluOp_t op);
        expClass = CLS_ALU_REG;
        expAluOp = op;
    endtask

    task setShift(input shiftType_t kind, input shiftSrc_t src);
        expClass     = CLS_SHIFT;
        expShiftType = kind;
        expShiftSrc  = src;
        expSource    = M2R_SHIFTER;
    endtask

    task setBranch(input aluOp_t op);
        expClass = CLS_BRANCH;
        expAluOp = op;
    endtask

    task decodeReference(input opcode_t op, input funct_t fn);
        expClass     = CLS_ILLEGAL;
        expAluOp     = ALU_ADD;
        expShiftType = SH_NONE;
        expShiftSrc  = SHS_REG;
        expSrcB      = SRCB_IMM;
        expDest      = RD_RT;
        expSource    = M2R_ALU_OUT;
        if (op == OP_RTYPE)
        begin
            expSrcB = SRCB_REG;
            expDest = RD_RD;
            case (fn)
                FN_ADD:  setRegAlu(ALU_ADD);
                FN_SUB:  setRegAlu(ALU_SUB);
                FN_AND:  setRegAlu(ALU_AND);
                FN_OR:   setRegAlu(ALU_OR);
                FN_SLT:  setRegAlu(ALU_SLT);
                FN_SLL:  setShift(SH_LEFT, SHS_SHAMT);
                FN_SRL:  setShift(SH_RIGHT_LOGIC, SHS_SHAMT);
                FN_SRA:  setShift(SH_RIGHT_ARITH, SHS_SHAMT);
                FN_SLLV: setShift(SH_LEFT, SHS_REG);
                FN_SRAV: setShift(SH_RIGHT_ARITH, SHS_REG);
                default: expClass = CLS_ILLEGAL;
            endcase
        end
        else
        begin
            case (op)
                OP_ADDI, OP_ADDIU: expClass = CLS_ALU_IMM;
                OP_SLTI:
                begin
                    expClass = CLS_ALU_IMM;
                    expAluOp = ALU_SLT;
                end
                OP_BEQ:  setBranch(ALU_EQ);
                OP_BNE:  setBranch(ALU_NE);
                OP_BLE:  setBranch(ALU_LE);
                OP_BGT:  setBranch(ALU_GT);
                OP_LW:
                begin
                    expClass  = CLS_LOAD;
                    expSource = M2R_MEM_DATA;
                end
                OP_SW:   expClass = CLS_STORE;
                OP_J:    expClass = CLS_JUMP;
                OP_JAL:
                begin
                    expClass  = CLS_JAL;
                    expDest   = RD_RA;
                    expSource = M2R_PC;
                end
                default: expClass = CLS_ILLEGAL;
            endcase
        end
    endtask

    task buildSteps();
        steps.delete();
        steps.push_back(ST_FETCH);
        steps.push_back(ST_DECODE);
        case (expClass)
            CLS_ALU_REG, CLS_ALU_IMM:
            begin
                steps.push_back(ST_EXECUTE);
                steps.push_back(ST_ALU_WRITEBACK);
            end
            CLS_SHIFT:
            begin
                steps.push_back(ST_SHIFT_LOAD);
                steps.push_back(ST_SHIFT_RUN);
                steps.push_back(ST_ALU_WRITEBACK);
            end
            CLS_BRANCH:
            begin
                steps.push_back(ST_BRANCH_TARGET);
                steps.push_back(ST_BRANCH_COMPARE);
            end
            CLS_LOAD:
            begin
                steps.push_back(ST_ADDR_CALC);
                steps.push_back(ST_MEM_READ);
                steps.push_back(ST_MEM_WAIT);
                steps.push_back(ST_MEM_WRITEBACK);
            end
            CLS_STORE:
            begin
                steps.push_back(ST_ADDR_CALC);
                steps.push_back(ST_MEM_WRITE);
            end
            CLS_JUMP, CLS_JAL: steps.push_back(ST_JUMP);
            default: ;  // undefined goes straight back to fetch
        endcase
    endtask

    function automatic controlWord_t expectedWord(input seqState_t st);
        controlWord_t w;
        w = IDLE_WORD;
        case (st)
            ST_FETCH:
            begin
                w.memRead = 1'b1;
                w.irWrite = 1'b1;
            end
            ST_DECODE:
            begin
                w.aluSrcB  = SRCB_FOUR;
                w.pcWrite  = 1'b1;
                w.pcSource = PCS_ALU_RESULT;
            end
            ST_EXECUTE:
            begin
                w.aluSrcA    = SRCA_REG;
                w.aluSrcB    = expSrcB;
                w.aluOp      = expAluOp;
                w.aluOutLoad = 1'b1;
            end
            ST_SHIFT_LOAD:
            begin
                w.shiftType = SH_LOAD;
                w.shiftSrc  = expShiftSrc;
            end
            ST_SHIFT_RUN: w.shiftType = expShiftType;
            ST_ALU_WRITEBACK, ST_MEM_WRITEBACK:
            begin
                w.regWrite = 1'b1;
                w.regDest  = expDest;
                w.memToReg = expSource;
            end
            ST_BRANCH_TARGET:
            begin
                w.aluSrcB    = SRCB_BRANCH_OFFSET;
                w.aluOutLoad = 1'b1;
            end
            ST_BRANCH_COMPARE:
            begin
                w.aluSrcA     = SRCA_REG;
                w.aluOp       = expAluOp;
                w.pcWriteCond = 1'b1;
                w.pcSource    = PCS_ALU_OUT;
            end
            ST_ADDR_CALC:
            begin
                w.aluSrcA    = SRCA_REG;
                w.aluSrcB    = SRCB_IMM;
                w.aluOutLoad = 1'b1;
            end
            ST_MEM_READ, ST_MEM_WAIT:
            begin
                w.iorD    = 1'b1;
                w.memRead = 1'b1;
            end
            ST_MEM_WRITE:
            begin
                w.iorD     = 1'b1;
                w.memWrite = 1'b1;
            end
            ST_JUMP:
            begin
                w.pcWrite = 1'b1;
                if (expClass == CLS_JAL)
                begin
                    w.regWrite = 1'b1;
                    w.regDest  = RD_RA;
                    w.memToReg = M2R_PC;
                end
            end
            default: w = IDLE_WORD;
        endcase
        return w;
    endfunction

    always @(posedge clk)
    begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES)
            abortRun($sformatf("Timeout: run still going after %0d cycles", cycles));
    end

    initial
    begin
        opcode <= OP_RTYPE;
        funct  <= FN_ADD;
        @(posedge clk);
        // idle through reset and one cycle past it
        do
        begin
            @(negedge clk);
            checkControlWord(ctrl, IDLE_WORD);
        end
        while (reset);

        for (int n = 0; n < NUM_INSTR; n++)
        begin
            @(posedge clk);  // edge that enters fetch
            pickInstruction();
            opcode <= nextOp;
            funct  <= nextFunct;
            decodeReference(nextOp, nextFunct);
            buildSteps();
            foreach (steps[k])
            begin
                if (k > 0)
                    @(posedge clk);
                @(negedge clk);
                checkControlWord(ctrl, expectedWord(steps[k]));
            end
        end
        $display("Everything OK");
        $finish;
    end

endmodule
